// File: verilog/pit_pkg.sv
package pit_pkg;

	// Table geometry
	localparam int pit_depth    = 1024;
	localparam int index_width  = 10;   // Hash, table index and buffer address
	localparam int prefix_width = 64;

	// Entry layout, valid on top then satisfied then the buffer address
	localparam int entry_width     = 12;
	localparam int entry_valid_bit = 11;
	localparam int entry_sat_bit   = 10;
	localparam int entry_addr_msb  = 9;

	// Result port shows satisfied bit and address only
	localparam int result_width = entry_sat_bit + 1;

	// Who sent the request
	typedef enum logic {
		req_interest,   // Consumer side
		req_data        // Upstream side
	} req_kind_e;

	// Outcome of one table lookup
	typedef enum logic [2:0] {
		res_inserted,
		res_aggregated,
		res_satisfied,
		res_duplicate,
		res_rejected
	} result_kind_e;

	// Table FSM
	typedef enum logic [1:0] {
		st_clear,   // Reset sweep
		st_idle,
		st_lookup,  // Entry read, update being computed
		st_respond  // Result on the output
	} table_state_e;

endpackage

// File: verilog/pit_req_if.sv
`timescale 1ns/100ps

interface pit_req_if;
	import pit_pkg::*;

	logic                     valid;  // Single-cycle strobe
	req_kind_e                kind;
	logic [prefix_width-1:0]  prefix;
	logic [index_width-1:0]   index;  // Filled in by the hash stage

	modport source (
		output valid,
		output kind,
		output prefix,
		output index
	);

	modport sink (
		input valid,
		input kind,
		input prefix,
		input index
	);

endinterface

// File: verilog/pit_request_select.sv
`timescale 1ns/100ps

module pit_request_select (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             interest_valid,
	input  logic [pit_pkg::prefix_width-1:0] interest_prefix,
	input  logic                             data_valid,
	input  logic [pit_pkg::prefix_width-1:0] data_prefix,
	input  logic                             busy,
	pit_req_if.source                        req,
	output logic                             drop,
	output pit_pkg::req_kind_e               drop_kind
);
	import pit_pkg::*;

	logic blocked;
	logic take_data;
	logic take_interest;
	logic drop_data;
	logic drop_interest;

	// Our own registered request counts as in flight too, the table cannot see it yet
	assign blocked = busy || req.valid;

	// Data wins a collision
	assign take_data     = data_valid && !blocked;
	assign take_interest = interest_valid && !data_valid && !blocked;

	assign drop_data     = data_valid && blocked;
	assign drop_interest = interest_valid && (blocked || data_valid);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			req.valid <= 1'b0;
			drop      <= 1'b0;
			drop_kind <= req_interest;
		end else begin
			req.valid <= take_data || take_interest;
			drop      <= drop_data || drop_interest;
			// Only one drop line, a refused data strobe is the one reported
			if (drop_data)
				drop_kind <= req_data;
			else if (drop_interest)
				drop_kind <= req_interest;
		end
	end

	// Request payload
	always_ff @(posedge clk) begin
		if (take_data) begin
			req.kind   <= req_data;
			req.prefix <= data_prefix;
		end else if (take_interest) begin
			req.kind   <= req_interest;
			req.prefix <= interest_prefix;
		end
	end

endmodule

// File: verilog/prefix_hash.sv
`timescale 1ns/100ps

module prefix_hash (
	input  logic      clk,
	input  logic      rst,
	pit_req_if.sink   req_in,
	pit_req_if.source req_out
);
	import pit_pkg::*;

	logic [index_width-1:0] fold;
	logic [index_width-1:0] top_slice;

	// Bits 63:60 are the short last slice
	assign top_slice = {{(index_width - 4){1'b0}}, req_in.prefix[63:60]};

	// Six full slices from bit 0 upward, then the short one
	always_comb begin
		fold = req_in.prefix[9:0];
		fold = fold ^ req_in.prefix[19:10];
		fold = fold ^ req_in.prefix[29:20];
		fold = fold ^ req_in.prefix[39:30];
		fold = fold ^ req_in.prefix[49:40];
		fold = fold ^ req_in.prefix[59:50];
		fold = fold ^ top_slice;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			req_out.valid <= 1'b0;
		else
			req_out.valid <= req_in.valid;
	end

	// Kind and index move together so the table sees them aligned
	always_ff @(posedge clk) begin
		if (req_in.valid) begin
			req_out.kind  <= req_in.kind;
			req_out.index <= fold;
		end
	end

endmodule

// File: verilog/pit_hash_table.sv
`timescale 1ns/100ps

module pit_hash_table (
	input  logic                             clk,
	input  logic                             rst,
	pit_req_if.sink                          req,
	output logic                             busy,
	output logic                             ready,
	output logic                             result_valid,
	output pit_pkg::result_kind_e            result_kind,
	output logic [pit_pkg::result_width-1:0] result_entry
);
	import pit_pkg::*;

	table_state_e state;

	logic [entry_width-1:0] mem [pit_depth];

	logic [index_width-1:0] clear_addr;   // Sweep pointer
	logic [index_width-1:0] alloc_addr;   // Next buffer address to hand out
	logic [index_width-1:0] cur_index;
	req_kind_e              cur_kind;
	logic [entry_width-1:0] rd_entry;
	logic [entry_width-1:0] new_entry;
	logic                   hit;
	logic                   wr_en;
	result_kind_e           res_kind;

	assign ready = (state != st_clear);

	// Respond state is free so the next strobe can be sampled at its end
	assign busy = (state == st_clear) || (state == st_lookup) || req.valid;

	assign hit = rd_entry[entry_valid_bit];

	// Update rules
	always_comb begin
		new_entry = rd_entry;
		res_kind  = res_rejected;
		wr_en     = 1'b0;
		if (cur_kind == req_interest) begin
			if (hit) begin
				res_kind = res_aggregated;     // Entry stays as it is
			end else begin
				new_entry[entry_valid_bit]        = 1'b1;
				new_entry[entry_sat_bit]          = 1'b0;
				new_entry[entry_addr_msb:0]       = alloc_addr;
				res_kind                          = res_inserted;
				wr_en                             = (state == st_lookup);
			end
		end else if (hit) begin
			new_entry[entry_sat_bit] = 1'b1;
			if (rd_entry[entry_sat_bit]) begin
				res_kind = res_duplicate;
			end else begin
				res_kind = res_satisfied;
				wr_en    = (state == st_lookup);
			end
		end
		// Data on a miss falls through as rejected
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= st_clear;
			clear_addr   <= '0;
			alloc_addr   <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			case (state)
				st_clear: begin
					clear_addr <= clear_addr + 1'b1;
					if (clear_addr == index_width'(pit_depth - 1))
						state <= st_idle;
				end
				st_idle: begin
					if (req.valid)
						state <= st_lookup;
				end
				st_lookup: begin
					result_valid <= 1'b1;
					state        <= st_respond;
					if (res_kind == res_inserted)
						alloc_addr <= alloc_addr + 1'b1;   // Wraps at the table size
				end
				st_respond: begin
					state <= st_idle;
				end
				default: begin
					state <= st_clear;
				end
			endcase
		end
	end

	// Storage, one port shared by the sweep and the update
	always_ff @(posedge clk) begin
		if (state == st_clear)
			mem[clear_addr] <= '0;
		else if (wr_en)
			mem[cur_index] <= new_entry;
		if (state == st_idle && req.valid)
			rd_entry <= mem[req.index];
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req.valid) begin
			cur_index <= req.index;
			cur_kind  <= req.kind;
		end
		if (state == st_lookup) begin
			result_kind <= res_kind;
			// Entry after the update, zero on reject
			if (res_kind == res_rejected)
				result_entry <= '0;
			else
				result_entry <= new_entry[result_width-1:0];
		end
	end

endmodule

// File: verilog/pit_top.sv
`timescale 1ns/100ps

module pit_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             interest_valid,
	input  logic [pit_pkg::prefix_width-1:0] interest_prefix,
	input  logic                             data_valid,
	input  logic [pit_pkg::prefix_width-1:0] data_prefix,
	output logic                             ready,
	output logic                             result_valid,
	output pit_pkg::result_kind_e            result_kind,
	output logic [pit_pkg::result_width-1:0] result_entry,
	output logic                             drop,
	output pit_pkg::req_kind_e               drop_kind
);

	logic busy;

	pit_req_if fe_req ();     // Front end to hash
	pit_req_if hash_req ();   // Hash to table

	pit_request_select u_select (
		.clk             (clk),
		.rst             (rst),
		.interest_valid  (interest_valid),
		.interest_prefix (interest_prefix),
		.data_valid      (data_valid),
		.data_prefix     (data_prefix),
		.busy            (busy),
		.req             (fe_req.source),
		.drop            (drop),
		.drop_kind       (drop_kind)
	);

	prefix_hash u_hash (
		.clk     (clk),
		.rst     (rst),
		.req_in  (fe_req.sink),
		.req_out (hash_req.source)
	);

	pit_hash_table u_table (
		.clk          (clk),
		.rst          (rst),
		.req          (hash_req.sink),
		.busy         (busy),
		.ready        (ready),
		.result_valid (result_valid),
		.result_kind  (result_kind),
		.result_entry (result_entry)
	);

endmodule

// File: verification/pit_clock_gen.sv
`timescale 1ns/100ps

module pit_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	// Reset held for the first 8 rising edges
	initial begin
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: verification/pit_properties.sv
`timescale 1ns/100ps

module pit_properties (
	input logic               clk,
	input logic               rst,
	input logic               interest_valid,
	input logic               data_valid,
	input logic               ready,
	input logic               result_valid,
	input logic               drop,
	input pit_pkg::req_kind_e drop_kind
);
	import pit_pkg::*;

	logic interest_q;
	logic data_q;
	logic accepted;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			interest_q <= 1'b0;
			data_q     <= 1'b0;
		end else begin
			interest_q <= interest_valid;
			data_q     <= data_valid;
		end
	end

	// Last cycle's strobe went in unless its drop shows now
	assign accepted = (data_q && (!drop || drop_kind == req_interest)) ||
	                  (interest_q && !data_q && !drop);

	a_result_pulse: assert property (@(posedge clk) disable iff (rst)
		result_valid |=> !result_valid)
		else $error("result_valid high for more than one cycle");

	a_drop_pulse: assert property (@(posedge clk) disable iff (rst)
		drop |=> !drop)
		else $error("drop high for more than one cycle");

	a_result_follows: assert property (@(posedge clk) disable iff (rst)
		$past(accepted, 3) |-> result_valid)
		else $error("accepted strobe gave no result three cycles later");

	a_no_stray_result: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(accepted, 3))
		else $error("result without a strobe three cycles before");

	a_quiet_in_sweep: assert property (@(posedge clk) disable iff (rst)
		!ready |-> !result_valid)
		else $error("result_valid while ready is low");

endmodule

bind pit_top pit_properties u_properties (
	.clk            (clk),
	.rst            (rst),
	.interest_valid (interest_valid),
	.data_valid     (data_valid),
	.ready          (ready),
	.result_valid   (result_valid),
	.drop           (drop),
	.drop_kind      (drop_kind)
);

// File: verification/pit_tb.sv
`timescale 1ns/100ps

module pit_tb;
	import pit_pkg::*;

	localparam int n_random     = 300;
	localparam int n_planned    = n_random + 20;
	localparam int limit_cycles = 8 + pit_depth + 8 * n_planned + 256;

	logic                    clk;
	logic                    rst;
	logic                    interest_valid;
	logic [prefix_width-1:0] interest_prefix;
	logic                    data_valid;
	logic [prefix_width-1:0] data_prefix;
	logic                    ready;
	logic                    result_valid;
	result_kind_e            result_kind;
	logic [result_width-1:0] result_entry;
	logic                    drop;
	req_kind_e               drop_kind;

	// Reference table
	logic                   model_valid [pit_depth];
	logic                   model_sat [pit_depth];
	logic [index_width-1:0] model_addr [pit_depth];
	logic [index_width-1:0] model_alloc;
	logic                   model_ready;
	int                     last_accept;

	result_kind_e            exp_kind_q [$];
	logic [result_width-1:0] exp_entry_q [$];
	int                      exp_due_q [$];
	req_kind_e               drop_kind_q [$];
	int                      drop_due_q [$];

	int    cyc = 0;   // Edge counter, read at a rising edge it gives that edge's index
	int    checks = 0;
	int    errors = 0;
	string test_name = "startup";
	logic [prefix_width-1:0] pool [12];

	pit_clock_gen u_clock_gen (.clk(clk), .rst(rst));

	pit_top u_pit_top (
		.clk             (clk),
		.rst             (rst),
		.interest_valid  (interest_valid),
		.interest_prefix (interest_prefix),
		.data_valid      (data_valid),
		.data_prefix     (data_prefix),
		.ready           (ready),
		.result_valid    (result_valid),
		.result_kind     (result_kind),
		.result_entry    (result_entry),
		.drop            (drop),
		.drop_kind       (drop_kind)
	);

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [index_width-1:0] fold_prefix(input logic [prefix_width-1:0] p);
		logic [index_width-1:0] idx;
		idx = '0;
		// Prefix bit i lands on index bit i mod 10
		for (int i = 0; i < prefix_width; i++)
			idx[i % index_width] = idx[i % index_width] ^ p[i];
		return idx;
	endfunction

	// Reference model of one lookup, updates the table copy
	function automatic void predict(input req_kind_e kind, input logic [prefix_width-1:0] p,
			output result_kind_e rk, output logic [result_width-1:0] re);
		logic [index_width-1:0] idx;
		idx = fold_prefix(p);
		if (kind == req_interest && !model_valid[idx]) begin
			model_valid[idx] = 1'b1;
			model_sat[idx]   = 1'b0;
			model_addr[idx]  = model_alloc;
			model_alloc      = model_alloc + index_width'(1);
			rk = res_inserted;
		end else if (kind == req_interest) begin
			rk = res_aggregated;
		end else if (!model_valid[idx]) begin
			rk = res_rejected;
		end else begin
			rk = model_sat[idx] ? res_duplicate : res_satisfied;
			model_sat[idx] = 1'b1;
		end
		re = (rk == res_rejected) ? '0 : {model_sat[idx], model_addr[idx]};
	endfunction

	function automatic void expect_result(input req_kind_e kind,
			input logic [prefix_width-1:0] p, input int s);
		result_kind_e            rk;
		logic [result_width-1:0] re;
		predict(kind, p, rk, re);
		exp_kind_q.push_back(rk);
		exp_entry_q.push_back(re);
		exp_due_q.push_back(s + 4);   // Seen at the falling edge after edge s+3
		last_accept = s;
	endfunction

	function automatic void expect_drop(input req_kind_e kind, input int s);
		drop_kind_q.push_back(kind);
		drop_due_q.push_back(s + 1);   // Seen at the falling edge after edge s
	endfunction

	function automatic logic [prefix_width-1:0] rand_prefix();
		return {$urandom, $urandom};
	endfunction

	// A prefix whose hash slot is still empty in the model
	function automatic logic [prefix_width-1:0] free_prefix();
		logic [prefix_width-1:0] p;
		do
			p = rand_prefix();
		while (model_valid[fold_prefix(p)]);
		return p;
	endfunction

	// Caller sits at a rising edge; the strobe is sampled at the next one
	task automatic send_strobe(input logic iv, input logic [prefix_width-1:0] ip,
			input logic dv, input logic [prefix_width-1:0] dp);
		int   s;
		logic blocked;
		s = cyc + 1;
		blocked = !model_ready || (s <= last_accept + 3);
		interest_valid  <= iv;
		interest_prefix <= ip;
		data_valid      <= dv;
		data_prefix     <= dp;
		if (dv && blocked) begin
			expect_drop(req_data, s);   // Both refused, data is the one reported
		end else if (dv) begin
			expect_result(req_data, dp, s);
			if (iv)
				expect_drop(req_interest, s);
		end else if (iv && blocked) begin
			expect_drop(req_interest, s);
		end else if (iv) begin
			expect_result(req_interest, ip, s);
		end
		@(posedge clk);
		interest_valid <= 1'b0;
		data_valid     <= 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_kind_q.size() != 0 || drop_kind_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic end_test(input int errors_before);
		wait_idle();
		if (errors == errors_before)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, errors - errors_before);
	endtask

	function automatic void check_result();
		result_kind_e            k;
		logic [result_width-1:0] e;
		int                      due;
		checks++;
		assert (exp_kind_q.size() != 0) else begin
			$display("** Error [%s]: a result came out with no request pending", test_name);
			errors++;
		end
		if (exp_kind_q.size() != 0) begin
			k   = exp_kind_q.pop_front();
			e   = exp_entry_q.pop_front();
			due = exp_due_q.pop_front();
			assert (result_kind == k) else begin
				$display("** Error [%s]: result kind expected %s, actual %s",
					test_name, k.name(), result_kind.name());
				errors++;
			end
			assert (result_entry == e) else begin
				$display("** Error [%s]: result entry expected %h, actual %h",
					test_name, e, result_entry);
				errors++;
			end
			assert (cyc == due) else begin
				$display("** Error [%s]: result cycle expected %0d, actual %0d",
					test_name, due, cyc);
				errors++;
			end
		end
	endfunction

	function automatic void check_drop();
		req_kind_e k;
		int        due;
		checks++;
		assert (drop_kind_q.size() != 0) else begin
			$display("** Error [%s]: drop reported for an accepted strobe", test_name);
			errors++;
		end
		if (drop_kind_q.size() != 0) begin
			k   = drop_kind_q.pop_front();
			due = drop_due_q.pop_front();
			assert (drop_kind == k && cyc == due) else begin
				$display("** Error [%s]: drop kind/cycle expected %s/%0d, actual %s/%0d",
					test_name, k.name(), due, drop_kind.name(), cyc);
				errors++;
			end
		end
	endfunction

	// Outputs sampled on the falling edge
	always @(negedge clk) begin
		if (!rst && result_valid)
			check_result();
		if (!rst && drop)
			check_drop();
	end

	initial begin
		#(limit_cycles * 8);
		$display("Timeout: run did not finish within %0d cycles", limit_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int                      base_errors;
		int                      rst_cycle;
		int                      mode;
		int                      gap;
		logic [prefix_width-1:0] pa;
		logic [prefix_width-1:0] pc;
		logic [prefix_width-1:0] m;

		void'($urandom(32'ha16e_0a09));
		interest_valid  <= 1'b0;
		interest_prefix <= '0;
		data_valid      <= 1'b0;
		data_prefix     <= '0;
		model_alloc = '0;
		model_ready = 1'b0;
		last_accept = -100;
		for (int i = 0; i < pit_depth; i++) begin
			model_valid[i] = 1'b0;
			model_sat[i]   = 1'b0;
			model_addr[i]  = '0;
		end

		@(posedge clk);
		while (rst)
			@(posedge clk);
		rst_cycle = cyc;

		// Everything is refused during the sweep
		test_name = "sweep_drop";
		base_errors = errors;
		send_strobe(1'b1, rand_prefix(), 1'b0, '0);
		repeat (2) @(posedge clk);
		send_strobe(1'b0, '0, 1'b1, rand_prefix());
		repeat (2) @(posedge clk);
		send_strobe(1'b1, rand_prefix(), 1'b1, rand_prefix());
		while (!ready)
			@(posedge clk);
		model_ready = 1'b1;
		checks++;
		assert (cyc == rst_cycle + pit_depth) else begin
			$display("** Error [%s]: ready rise cycle expected %0d, actual %0d",
				test_name, rst_cycle + pit_depth, cyc);
			errors++;
		end
		end_test(base_errors);

		test_name = "insert_aggregate";
		base_errors = errors;
		pa = free_prefix();
		send_strobe(1'b1, pa, 1'b0, '0);
		wait_idle();
		send_strobe(1'b1, pa, 1'b0, '0);
		end_test(base_errors);

		test_name = "satisfy_duplicate";
		base_errors = errors;
		send_strobe(1'b0, '0, 1'b1, pa);
		wait_idle();
		send_strobe(1'b0, '0, 1'b1, pa);
		end_test(base_errors);

		test_name = "reject";
		base_errors = errors;
		send_strobe(1'b0, '0, 1'b1, free_prefix());
		end_test(base_errors);

		// Busy drops of both kinds, then a same-cycle collision
		test_name = "busy_collision";
		base_errors = errors;
		pc = free_prefix();
		send_strobe(1'b1, pc, 1'b0, '0);
		send_strobe(1'b0, '0, 1'b1, pa);
		@(posedge clk);
		send_strobe(1'b1, free_prefix(), 1'b0, '0);
		wait_idle();
		send_strobe(1'b1, free_prefix(), 1'b1, pc);
		end_test(base_errors);

		// Pool of 8 prefixes plus 4 partners that hash to the same slot
		test_name = "random_mix";
		base_errors = errors;
		for (int i = 0; i < 8; i++)
			pool[i] = rand_prefix();
		for (int i = 0; i < 4; i++) begin
			m = '0;
			m[9:0]   = index_width'($urandom) | index_width'(1);
			m[19:10] = m[9:0];
			pool[8 + i] = pool[i] ^ m;
		end
		for (int n = 0; n < n_random; n++) begin
			mode = $urandom_range(9, 0);
			gap  = $urandom_range(5, 1);
			if (mode < 6)
				send_strobe(1'b1, pool[$urandom_range(11, 0)], 1'b0, '0);
			else if (mode < 9)
				send_strobe(1'b0, '0, 1'b1, pool[$urandom_range(11, 0)]);
			else
				send_strobe(1'b1, pool[$urandom_range(11, 0)], 1'b1, pool[$urandom_range(11, 0)]);
			repeat (gap) @(posedge clk);   // Keeps drops apart
		end
		end_test(base_errors);

		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: tb.f
verilog/pit_pkg.sv
verilog/pit_req_if.sv
verilog/pit_request_select.sv
verilog/prefix_hash.sv
verilog/pit_hash_table.sv
verilog/pit_top.sv
verification/pit_clock_gen.sv
verification/pit_properties.sv
verification/pit_tb.sv

// File: Makefile
# Verilator build and run for the PIT testbench

VERILATOR ?= verilator
TOP       ?= pit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
